// File: hdl/rf_settings.svh
// register file geometry
`ifndef RF_SETTINGS_SVH
`define RF_SETTINGS_SVH

//////////////////////////////////////////////////
// array shape
//////////////////////////////////////////////////

// number of entries and address width to reach them
`define RF_ENTRIES 16
`define RF_ADDR_W 4

// full entry width
`define RF_DATA_W 160

//////////////////////////////////////////////////
// write mask structure
//////////////////////////////////////////////////

// one byte enable per lane, lanes are 8 bits wide
`define RF_LANE_W 8
`define RF_LANES 20

// bit k of a lane follows word enable k mod 4
`define RF_WORDS 4

`endif

// File: hdl/rf_pkg.sv
// register file request types
`include "rf_settings.svh"

package rf_pkg;

	//////////////////////////////////////////////////
	// write request
	//////////////////////////////////////////////////

	// the enable sits in the top bit
	// the staging register relies on that to clear it under reset
	typedef struct packed {
		logic wr_en;
		logic [`RF_WORDS-1:0] word_wen;
		logic [`RF_LANES-1:0] byte_wen;
		logic [`RF_ADDR_W-1:0] addr;
		logic [`RF_DATA_W-1:0] data;
	} rf_wr_req_t;

	//////////////////////////////////////////////////
	// read request
	//////////////////////////////////////////////////

	// same layout rule, enable first
	typedef struct packed {
		logic read_en;
		logic [`RF_ADDR_W-1:0] addr;
	} rf_rd_req_t;

	//////////////////////////////////////////////////
	// lane payload
	//////////////////////////////////////////////////

	// one byte lane of an entry
	typedef logic [`RF_LANE_W-1:0] rf_lane_data_t;

endpackage

// File: hdl/rf_capture_stage.sv
// request staging register
module rf_capture_stage #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset_l,
	input logic sehold,
	input payload_t d,
	output payload_t q
);

	// enable is the most significant bit of every payload
	localparam int unsigned PW = $bits(payload_t);

	//////////////////////////////////////////////////
	// staging flop
	//////////////////////////////////////////////////

	// sehold freezes the whole request
	// reset only touches the enable bit and wins over the hold
	always_ff @(posedge clk)
	begin
		if (!sehold)
		begin
			q <= d;
		end
		if (reset_l)
		begin
			q[PW-1] <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// an unknown enable would write or read garbage one cycle later
	a_enable_known: assert property (
		@(posedge clk) disable iff (reset_l)
		!$isunknown(d[PW-1])
	) else $error("request enable is unknown outside reset");

endmodule

// File: hdl/rf_byte_lane.sv
// one byte lane of the register file
`include "rf_settings.svh"

module rf_byte_lane (
	input logic clk,
	input logic reset_l,

	// write side, staged one cycle upstream
	input logic wr_en,
	input logic byte_wen,
	input logic [`RF_WORDS-1:0] word_wen,
	input logic [`RF_ADDR_W-1:0] wr_addr,
	input rf_pkg::rf_lane_data_t wr_data,

	// read side, staged as well
	input logic [`RF_ADDR_W-1:0] rd_addr,
	input logic read_en,
	output rf_pkg::rf_lane_data_t rd_data
);

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	// no reset on the array, contents are undefined until written
	rf_pkg::rf_lane_data_t mem [`RF_ENTRIES];

	// per-bit write mask for this lane
	rf_pkg::rf_lane_data_t bit_mask;

	// lane takes part in the write at all
	logic lane_we;

	//////////////////////////////////////////////////
	// write mask
	//////////////////////////////////////////////////

	// bits 0 and 4 share word enable 0, bits 1 and 5 word enable 1, and so on
	always_comb
	begin
		for (int k = 0; k < `RF_LANE_W; k++)
		begin
			bit_mask[k] = word_wen[k % `RF_WORDS];
		end
	end

	assign lane_we = wr_en & byte_wen;

	//////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////

	// masked bits keep the old entry value
	always_ff @(posedge clk)
	begin
		if (lane_we)
		begin
			mem[wr_addr] <= (mem[wr_addr] & ~bit_mask) | (wr_data & bit_mask);
		end
	end

	//////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////

	// loads from the array before the same-edge write lands,
	// so a colliding read returns the old contents
	always_ff @(posedge clk)
	begin
		if (reset_l)
		begin
			rd_data <= '0;
		end
		else if (read_en)
		begin
			rd_data <= mem[rd_addr];
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// addresses come from the staging registers in the top level
	a_wr_addr_known: assert property (
		@(posedge clk) disable iff (reset_l)
		wr_en |-> !$isunknown(wr_addr)
	) else $error("write address unknown with write enabled");

	a_rd_addr_known: assert property (
		@(posedge clk) disable iff (reset_l)
		read_en |-> !$isunknown(rd_addr)
	) else $error("read address unknown with read enabled");

endmodule

// File: hdl/rf16x160.sv
// 16 x 160 register file, one read and one write port
`include "rf_settings.svh"

module rf16x160 (
	input logic clk,
	input logic reset_l,
	input logic [`RF_DATA_W-1:0] din,
	input logic [`RF_ADDR_W-1:0] wr_adr,
	input logic [`RF_ADDR_W-1:0] rd_adr,
	input logic wr_en,
	input logic read_en,
	input logic rst_tri_en,
	input logic sehold,
	input logic [`RF_WORDS-1:0] word_wen,
	input logic [`RF_LANES-1:0] byte_wen,
	output logic [`RF_DATA_W-1:0] dout
);

	// raw and staged requests
	rf_pkg::rf_wr_req_t wr_req;
	rf_pkg::rf_wr_req_t wr_req_q;
	rf_pkg::rf_rd_req_t rd_req;
	rf_pkg::rf_rd_req_t rd_req_q;

	//////////////////////////////////////////////////
	// request packing
	//////////////////////////////////////////////////

	// rst_tri_en blocks the write before it is staged
	always_comb
	begin
		wr_req.wr_en = wr_en & ~rst_tri_en;
		wr_req.word_wen = word_wen;
		wr_req.byte_wen = byte_wen;
		wr_req.addr = wr_adr;
		wr_req.data = din;
	end

	always_comb
	begin
		rd_req.read_en = read_en;
		rd_req.addr = rd_adr;
	end

	//////////////////////////////////////////////////
	// input staging
	//////////////////////////////////////////////////

	rf_capture_stage #(
		.payload_t(rf_pkg::rf_wr_req_t)
	) u_wr_stage (
		.clk(clk),
		.reset_l(reset_l),
		.sehold(sehold),
		.d(wr_req),
		.q(wr_req_q)
	);

	rf_capture_stage #(
		.payload_t(rf_pkg::rf_rd_req_t)
	) u_rd_stage (
		.clk(clk),
		.reset_l(reset_l),
		.sehold(sehold),
		.d(rd_req),
		.q(rd_req_q)
	);

	//////////////////////////////////////////////////
	// byte lanes
	//////////////////////////////////////////////////

	// each lane owns 8 bits of every entry and one byte enable
	for (genvar g = 0; g < `RF_LANES; g++)
	begin : g_lane
		rf_byte_lane u_lane (
			.clk(clk),
			.reset_l(reset_l),
			.wr_en(wr_req_q.wr_en),
			.byte_wen(wr_req_q.byte_wen[g]),
			.word_wen(wr_req_q.word_wen),
			.wr_addr(wr_req_q.addr),
			.wr_data(wr_req_q.data[g*`RF_LANE_W +: `RF_LANE_W]),
			.rd_addr(rd_req_q.addr),
			.read_en(rd_req_q.read_en),
			.rd_data(dout[g*`RF_LANE_W +: `RF_LANE_W])
		);
	end

endmodule

// File: test/tb_rf16x160.sv
// register file testbench
`include "rf_settings.svh"

module tb_rf16x160;

	localparam string TEST_FILE = "test/rf_tests.txt";

	// one operation from the test file
	typedef struct packed {
		int src_line;
		logic [7:0] op;
		logic [`RF_ADDR_W-1:0] addr;
		logic [`RF_WORDS-1:0] word_wen;
		logic [`RF_LANES-1:0] byte_wen;
		logic [`RF_DATA_W-1:0] data;
	} test_line_t;

	// a read result that is due at a later cycle
	typedef struct packed {
		int due;
		int src_line;
		logic [7:0] op;
		logic [`RF_ADDR_W-1:0] addr;
		logic [`RF_DATA_W-1:0] expected;
	} pending_check_t;

	logic clk;
	logic reset_l;
	logic [`RF_DATA_W-1:0] din;
	logic [`RF_ADDR_W-1:0] wr_adr;
	logic [`RF_ADDR_W-1:0] rd_adr;
	logic wr_en;
	logic read_en;
	logic rst_tri_en;
	logic sehold;
	logic [`RF_WORDS-1:0] word_wen;
	logic [`RF_LANES-1:0] byte_wen;
	logic [`RF_DATA_W-1:0] dout;

	test_line_t tests[$];
	pending_check_t pending[$];
	int cycle_count = 0;
	int cycle_limit = 0;
	int pass_count = 0;
	int fail_count = 0;

	rf16x160 UUT (
		.clk(clk),
		.reset_l(reset_l),
		.din(din),
		.wr_adr(wr_adr),
		.rd_adr(rd_adr),
		.wr_en(wr_en),
		.read_en(read_en),
		.rst_tri_en(rst_tri_en),
		.sehold(sehold),
		.word_wen(word_wen),
		.byte_wen(byte_wen),
		.dout(dout)
	);

	//////////////////////////////////////////////////
	// clock and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#50 clk = ~clk;
		end
	end

	// limit is set once the test file is loaded
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("the run timed out: tests not finished after %0d clock cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic compare_value(input logic [`RF_DATA_W-1:0] actual,
		input logic [`RF_DATA_W-1:0] expected, input string what, output logic ok);
		ok = (actual === expected);
		if (!ok)
		begin
			$display("FAILED at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic record_result(input logic ok, input string name);
		if (ok)
		begin
			pass_count++;
			$display("%s: passed", name);
		end
		else
		begin
			fail_count++;
			$display("%s: failed", name);
		end
	endtask

	// lines starting with # are comments
	task automatic load_tests(output logic ok);
		int fd;
		int fields;
		int line_no;
		string text;
		byte first;
		logic [7:0] op;
		logic [`RF_ADDR_W-1:0] addr;
		logic [`RF_WORDS-1:0] wwen;
		logic [`RF_LANES-1:0] bwen;
		logic [`RF_DATA_W-1:0] data;
		test_line_t entry;
		ok = 1'b1;
		line_no = 0;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0)
		begin
			$display("could not open the test file %s", TEST_FILE);
			ok = 1'b0;
		end
		else
		begin
			while (!$feof(fd) && ok)
			begin
				text = "";
				void'($fgets(text, fd));
				line_no++;
				first = (text.len() > 0) ? text.getc(0) : "#";
				if (first != "#" && first != "\n" && first != "\r")
				begin
					fields = $sscanf(text, "%c %h %h %h %h", op, addr, wwen, bwen, data);
					if (fields != 5 || !(op == "W" || op == "R" || op == "H" || op == "X"
						|| op == "C"))
					begin
						$display("test file line %0d cannot be understood", line_no);
						ok = 1'b0;
					end
					else
					begin
						entry.src_line = line_no;
						entry.op = op;
						entry.addr = addr;
						entry.word_wen = wwen;
						entry.byte_wen = bwen;
						entry.data = data;
						tests.push_back(entry);
					end
				end
			end
			$fclose(fd);
			if (ok && tests.size() == 0)
			begin
				$display("the test file holds no operations");
				ok = 1'b0;
			end
		end
	endtask

	task automatic drive_idle();
		wr_en = 1'b0;
		read_en = 1'b0;
		rst_tri_en = 1'b0;
		sehold = 1'b0;
	endtask

	// C reads and writes one address at once, writing the inverse of the expected old data
	task automatic drive_line(input test_line_t t);
		drive_idle();
		wr_adr = t.addr;
		rd_adr = t.addr;
		word_wen = t.word_wen;
		byte_wen = t.byte_wen;
		din = t.data;
		case (t.op)
			"W": wr_en = 1'b1;
			"R": read_en = 1'b1;
			"X":
			begin
				wr_en = 1'b1;
				rst_tri_en = 1'b1;
			end
			"H":
			begin
				wr_en = 1'b1;
				read_en = 1'b1;
				sehold = 1'b1;
			end
			"C":
			begin
				wr_en = 1'b1;
				read_en = 1'b1;
				din = ~t.data;
			end
			default: wr_en = 1'b0;
		endcase
	endtask

	task automatic run_due_checks(input int cycle);
		pending_check_t p;
		logic ok;
		string name;
		while (pending.size() > 0 && pending[0].due == cycle)
		begin
			p = pending.pop_front();
			name = $sformatf("line %0d, %c at address %h", p.src_line, p.op, p.addr);
			compare_value(dout, p.expected, name, ok);
			record_result(ok, name);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic loaded;
		logic ok;
		int cycle;
		pending_check_t p;
		reset_l = 1'b1;
		din = '0;
		wr_adr = '0;
		rd_adr = '0;
		word_wen = '0;
		byte_wen = '0;
		drive_idle();
		load_tests(loaded);
		if (!loaded)
		begin
			$display("no tests were run because the test file could not be used");
			$display("TEST RESULT: FAIL");
			$finish;
		end
		else
		begin
			cycle_limit = 3 * tests.size() + 50;
			repeat (8) @(posedge clk);
			#10;
			reset_l = 1'b0;
			compare_value(dout, '0, "dout after reset", ok);
			record_result(ok, "dout is zero after reset");

			// one line per cycle, read data is checked two cycles after driving
			for (int i = 0; i < tests.size(); i++)
			begin
				if (i > 0)
				begin
					@(posedge clk);
					#10;
				end
				run_due_checks(i);
				drive_line(tests[i]);
				if (tests[i].op == "R" || tests[i].op == "C")
				begin
					p.due = i + 2;
					p.src_line = tests[i].src_line;
					p.op = tests[i].op;
					p.addr = tests[i].addr;
					p.expected = tests[i].data;
					pending.push_back(p);
				end
				else if (tests[i].op == "H" && i > 0 && tests[i-1].op == "R")
				begin
					// the held read repeats the read of the line before
					p.due = i + 2;
					p.src_line = tests[i].src_line;
					p.op = tests[i].op;
					p.addr = tests[i-1].addr;
					p.expected = tests[i-1].data;
					pending.push_back(p);
				end
			end

			cycle = tests.size();
			while (pending.size() > 0)
			begin
				@(posedge clk);
				#10;
				drive_idle();
				run_due_checks(cycle);
				cycle++;
			end

			$display("checks done: %0d passed, %0d failed", pass_count, fail_count);
			if (fail_count == 0)
			begin
				$display("TEST RESULT: PASS");
			end
			else
			begin
				$display("TEST RESULT: FAIL");
			end
			$finish;
		end
	end

endmodule

// File: test/rf_tests.txt
# op addr word_wen byte_wen data, all hex; W write, R read, X write with rst_tri_en, H sehold
# on R and C lines data is the expected dout; C writes the inverted data to the same address
W 0 f fffff 0123456789abcdef0123456789abcdef01234567
W 1 f fffff fedcba9876543210fedcba9876543210fedcba98
W 2 f fffff a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
W 3 f fffff 00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff
R 0 0 00000 0123456789abcdef0123456789abcdef01234567
R 1 0 00000 fedcba9876543210fedcba9876543210fedcba98
R 2 0 00000 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
R 3 0 00000 00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff
# partial writes, lanes 0 to 3 with mask 33, lanes 16 to 19 with mask cc
W 2 3 0000f 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
W 3 c f0000 ffffffffffffffffffffffffffffffffffffffff
R 2 0 00000 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a596969696
R 3 0 00000 ccffccff00ff00ff00ff00ff00ff00ff00ff00ff
# write blocked by rst_tri_en
X 1 f fffff 0000000000000000000000000000000000000000
R 1 0 00000 fedcba9876543210fedcba9876543210fedcba98
# read and write to one address on the same edge
C 0 f fffff 0123456789abcdef0123456789abcdef01234567
R 0 0 00000 fedcba9876543210fedcba9876543210fedcba98
# sehold repeats the staged write, new data ignored
W 4 f fffff 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
H 4 f fffff c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3
R 4 0 00000 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
# sehold repeats the staged read, held write to address 2 ignored
R 1 0 00000 fedcba9876543210fedcba9876543210fedcba98
H 2 f fffff 0000000000000000000000000000000000000000
R 2 0 00000 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a596969696

// File: filelist.f
+incdir+hdl
hdl/rf_pkg.sv
hdl/rf_capture_stage.sv
hdl/rf_byte_lane.sv
hdl/rf16x160.sv
test/tb_rf16x160.sv

// File: run_sim.sh
#!/bin/sh
# build the register file testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rf16x160 \
	-f filelist.f --Mdir obj_dir -o sim_rf16x160
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/sim_rf16x160)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx 'TEST RESULT: PASS'; then
	exit 0
fi

echo "pass message not found in the simulation output"
exit 1
